//--- filelist.f
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_control.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_pc_unit.sv
rtl/rv_core.sv
bench/rv_core_properties.sv
bench/rv_core_tb.sv

//--- bench/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

	import rv_pkg::*;

	localparam logic [6:0] OP_R = 7'b0110011;
	localparam logic [6:0] OP_I = 7'b0010011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [31:0] ECALL = 32'h0000_0073;
	localparam int MEM_WORDS = 256;
	localparam int BASE_WORD = (RESET_PC >> 2) % MEM_WORDS;
	localparam int TIMEOUT = 500;

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	logic [31:0] dmem_rdata;
	logic        halted;
	logic        illegal;

	logic [31:0] imem [MEM_WORDS];
	logic [31:0] dmem [MEM_WORDS];
	logic [31:0] snap [MEM_WORDS];
	// R-type order is funct3 0..7 followed by SUB and SRA
	logic [2:0]  r_f3 [10] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7, 3'd0, 3'd5};
	logic        r_alt [10] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
	logic [2:0]  imm_f3 [5] = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7};
	// x1 and x4 hold the same negative value and x2 a positive one
	logic [2:0]  br_f3 [8] = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4, 3'd5, 3'd5};
	logic [4:0]  br_rs1 [8] = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
	logic [4:0]  br_rs2 [8] = '{5'd4, 5'd2, 5'd2, 5'd4, 5'd2, 5'd1, 5'd1, 5'd2};
	integer      seed;
	int          n_instr;
	int          errors;
	int          checks;

	rv_core u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.dmem_addr (dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we   (dmem_we),
		.dmem_rdata(dmem_rdata),
		.halted    (halted),
		.illegal   (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	always @(posedge clk) begin
		if (dmem_we === 1'b1) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
		end
	end

	function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_R};
	endfunction

	function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd);
		return {imm, rd, OP_LUI};
	endfunction

	function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	function automatic logic [31:0] sext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] fill_word(logic [31:0] addr);
		return {16'hd00d, addr[15:0]};
	endfunction

	function automatic logic [31:0] isa_result(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			default: return $signed(a) >= $signed(b);
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input logic [31:0] addr, input logic [31:0] exp);
		check_value($sformatf("dmem[%h]", addr), dmem[addr[9:2]], exp);
	endtask

	task automatic clear_mem();
		// Stray fetches land on ECALL
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = ECALL;
			dmem[i] <= fill_word(32'(i * 4));
		end
		n_instr = 0;
	endtask

	task automatic emit(input logic [31:0] instr);
		imem[(BASE_WORD + n_instr) % MEM_WORDS] = instr;
		n_instr++;
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		// Round up so the sign-extended ADDI lands on value
		upper = value + 32'h800;
		emit(u_type(upper[31:12], rd));
		emit(i_type(value[11:0], rd, 3'd0, rd, OP_I));
	endtask

	task automatic start_test();
		@(negedge clk);
		rst_n = 1'b0;
		clear_mem();
	endtask

	task automatic run_program(input string name);
		int cycles;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value("imem_addr", imem_addr, RESET_PC);
		check_value("dmem_we", dmem_we, 0);
		check_value("halted", halted, 0);
		check_value("illegal", illegal, 0);
		cycles = 0;
		while (halted !== 1'b1 && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			$display("timeout: program %s did not halt within %0d cycles", name, cycles);
			errors++;
		end
	endtask

	task automatic alu_ops();
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm [5];
		start_test();
		a = $random(seed);
		b = $random(seed);
		load_const(5'd1, a);
		load_const(5'd2, b);
		for (int k = 0; k < 10; k++) begin
			emit(r_type(r_alt[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, r_f3[k], 5'd3));
			emit(s_type(12'(32'h100 + k * 4), 5'd3, 5'd0));
		end
		for (int j = 0; j < 5; j++) begin
			imm[j] = 12'($random(seed));
			emit(i_type(imm[j], 5'd1, imm_f3[j], 5'd3, OP_I));
			emit(s_type(12'(32'h200 + j * 4), 5'd3, 5'd0));
		end
		emit(ECALL);
		run_program("alu");
		for (int k = 0; k < 10; k++) begin
			check_word(32'h100 + k * 4, isa_result(r_f3[k], r_alt[k], a, b));
		end
		for (int j = 0; j < 5; j++) begin
			check_word(32'h200 + j * 4, isa_result(imm_f3[j], 1'b0, a, sext12(imm[j])));
		end
	endtask

	task automatic immediate_offsets();
		logic [31:0] value;
		start_test();
		value = $random(seed);
		load_const(5'd5, 32'h300);
		load_const(5'd6, value);
		emit(s_type(-12'sd196, 5'd6, 5'd5));
		emit(i_type(-12'sd196, 5'd5, 3'd2, 5'd7, OP_LOAD));
		emit(s_type(-12'sd12, 5'd7, 5'd5));
		emit(i_type(-12'sd100, 5'd7, 3'd0, 5'd8, OP_I));
		emit(s_type(-12'sd4, 5'd8, 5'd5));
		// Most negative I immediate
		emit(i_type(12'h800, 5'd0, 3'd0, 5'd9, OP_I));
		emit(s_type(-12'sd8, 5'd9, 5'd5));
		emit(ECALL);
		run_program("immediates");
		check_word(32'h300 - 32'd196, value);
		check_word(32'h300 - 32'd12, value);
		check_word(32'h300 - 32'd4, value - 32'd100);
		check_word(32'h300 - 32'd8, 32'hffff_f800);
	endtask

	task automatic branch_paths();
		logic [31:0] neg;
		logic [31:0] pos;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] addr;
		logic        taken;
		start_test();
		neg = $random(seed) | 32'h8000_0000;
		pos = $random(seed) & 32'h7fff_ffff;
		load_const(5'd1, neg);
		load_const(5'd2, pos);
		load_const(5'd4, neg);
		// Not-taken path, jump over taken path, then taken path
		for (int k = 0; k < 8; k++) begin
			emit(b_type(13'd16, br_rs1[k], br_rs2[k], br_f3[k]));
			emit(i_type(12'(32'h500 + 2 * k), 5'd0, 3'd0, 5'd10, OP_I));
			emit(s_type(12'(32'h300 + 8 * k), 5'd10, 5'd0));
			emit(j_type(21'd12, 5'd0));
			emit(i_type(12'(32'h501 + 2 * k), 5'd0, 3'd0, 5'd10, OP_I));
			emit(s_type(12'(32'h304 + 8 * k), 5'd10, 5'd0));
		end
		emit(ECALL);
		run_program("branches");
		for (int k = 0; k < 8; k++) begin
			v1 = (br_rs1[k] == 5'd2) ? pos : neg;
			v2 = (br_rs2[k] == 5'd2) ? pos : neg;
			taken = branch_taken(br_f3[k], v1, v2);
			for (int p = 0; p < 2; p++) begin
				addr = 32'h300 + 8 * k + 4 * p;
				if (taken == 1'(p)) begin
					check_word(addr, 32'h500 + 2 * k + p);
				end else begin
					check_word(addr, fill_word(addr));
				end
			end
		end
	endtask

	task automatic jal_link();
		start_test();
		emit(i_type(12'h077, 5'd0, 3'd0, 5'd10, OP_I));
		emit(j_type(21'h200, 5'd1));
		emit(s_type(12'h080, 5'd10, 5'd0));
		// Jump lands 0x200 past the JAL at word 1
		n_instr = 1 + 32'h200 / 4;
		emit(s_type(12'h084, 5'd1, 5'd0));
		emit(ECALL);
		run_program("jal");
		check_word(32'h080, fill_word(32'h080));
		check_word(32'h084, RESET_PC + 32'd8);
	endtask

	task automatic ecall_halt();
		start_test();
		emit(i_type(12'h055, 5'd0, 3'd0, 5'd10, OP_I));
		emit(s_type(12'h090, 5'd10, 5'd0));
		emit(ECALL);
		emit(s_type(12'h094, 5'd10, 5'd0));
		run_program("ecall");
		check_value("halted", halted, 1);
		check_value("illegal", illegal, 0);
		for (int i = 0; i < MEM_WORDS; i++) begin
			snap[i] = dmem[i];
		end
		repeat (20) @(negedge clk);
		check_value("halted", halted, 1);
		check_value("illegal", illegal, 0);
		for (int i = 0; i < MEM_WORDS; i++) begin
			check_word(32'(i * 4), snap[i]);
		end
		check_word(32'h090, 32'h55);
		check_word(32'h094, fill_word(32'h094));
	endtask

	task automatic illegal_opcode();
		start_test();
		emit(i_type(12'h066, 5'd0, 3'd0, 5'd10, OP_I));
		emit(s_type(12'h09c, 5'd10, 5'd0));
		// custom-0 opcode lies outside the subset
		emit(32'h0000_000b);
		emit(s_type(12'h098, 5'd10, 5'd0));
		run_program("illegal");
		check_value("halted", halted, 1);
		check_value("illegal", illegal, 1);
		check_word(32'h09c, 32'h66);
		check_word(32'h098, fill_word(32'h098));
	endtask

	task automatic x0_writes();
		start_test();
		load_const(5'd1, 32'h1234_5678);
		emit(i_type(12'h123, 5'd0, 3'd0, 5'd0, OP_I));
		emit(u_type(20'habcde, 5'd0));
		emit(r_type(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
		emit(s_type(12'h0a0, 5'd0, 5'd0));
		emit(i_type(12'h000, 5'd0, 3'd0, 5'd11, OP_I));
		emit(s_type(12'h0a4, 5'd11, 5'd0));
		emit(ECALL);
		run_program("x0");
		check_word(32'h0a0, 32'h0);
		check_word(32'h0a4, 32'h0);
	endtask

	initial begin
		seed = 32'hbb5cb3a5;
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		clear_mem();
		repeat (3) alu_ops();
		immediate_offsets();
		branch_paths();
		jal_link();
		ecall_halt();
		illegal_opcode();
		x0_writes();
		@(negedge clk);
		$display("checks: %0d, failed checks: %0d, property failures: %0d",
			checks, errors, u_dut.u_props.fail_count);
		if (errors == 0 && u_dut.u_props.fail_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/rv_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    halted,
	input logic                    dmem_we,
	input logic [rv_pkg::XLEN-1:0] imem_addr,
	input logic [rv_pkg::XLEN-1:0] pc
);

	int fail_count = 0;

	no_store_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> !dmem_we)
		else begin
			$error("store request while halted");
			fail_count++;
		end

	// Only reset may leave HALT
	halt_is_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted)
		else begin
			$error("halted dropped without reset");
			fail_count++;
		end

	fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		imem_addr[1:0] == 2'b00)
		else begin
			$error("instruction fetch address not word aligned");
			fail_count++;
		end

	pc_frozen_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> $stable(pc))
		else begin
			$error("pc moved while halted");
			fail_count++;
		end

endmodule

bind rv_core rv_core_properties u_props (
	.clk      (clk),
	.rst_n    (rst_n),
	.halted   (halted),
	.dmem_we  (dmem_we),
	.imem_addr(imem_addr),
	.pc       (pc)
);

`default_nettype wire

//--- rtl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input  logic                    clk,
	input  logic                    rst_n,
	output logic [rv_pkg::XLEN-1:0] imem_addr,
	input  logic [31:0]             imem_data,
	output logic [rv_pkg::XLEN-1:0] dmem_addr,
	output logic [rv_pkg::XLEN-1:0] dmem_wdata,
	output logic                    dmem_we,
	input  logic [rv_pkg::XLEN-1:0] dmem_rdata,
	output logic                    halted,
	output logic                    illegal
);

	import rv_pkg::*;

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [4:0]      rd;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	alu_op_e         alu_op;
	logic            alu_src_imm;
	branch_e         branch;
	logic            reg_we;
	wb_sel_e         wb_sel;
	logic            mem_we;
	logic            pc_en;

	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] rd_data;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_plus4;

	rv_decoder u_decoder (
		.instr (imem_data),
		.opcode(opcode),
		.funct3(funct3),
		.funct7(funct7),
		.rs1   (rs1),
		.rs2   (rs2),
		.rd    (rd),
		.imm_i (imm_i),
		.imm_s (imm_s),
		.imm_b (imm_b),
		.imm_u (imm_u),
		.imm_j (imm_j)
	);

	rv_control u_control (
		.clk        (clk),
		.rst_n      (rst_n),
		.opcode     (opcode),
		.funct3     (funct3),
		.funct7     (funct7),
		.alu_op     (alu_op),
		.alu_src_imm(alu_src_imm),
		.branch     (branch),
		.reg_we     (reg_we),
		.wb_sel     (wb_sel),
		.mem_we     (mem_we),
		.pc_en      (pc_en),
		.halted     (halted),
		.illegal    (illegal)
	);

	rv_regfile u_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1_addr(rs1),
		.rs2_addr(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.we      (reg_we),
		.rd_addr (rd),
		.rd_data (rd_data)
	);

	// Stores take their offset from the S layout
	assign alu_b = !alu_src_imm ? rs2_data :
		(opcode == OPC_STORE) ? imm_s : imm_i;

	rv_alu u_alu (
		.op    (alu_op),
		.a     (rs1_data),
		.b     (alu_b),
		.result(alu_result)
	);

	rv_pc_unit u_pc_unit (
		.clk     (clk),
		.rst_n   (rst_n),
		.en      (pc_en),
		.branch  (branch),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.imm_b   (imm_b),
		.imm_j   (imm_j),
		.pc      (pc),
		.pc_plus4(pc_plus4)
	);

	always_comb begin
		case (wb_sel)
			WB_MEM:   rd_data = dmem_rdata;
			WB_PC4:   rd_data = pc_plus4;
			WB_IMM_U: rd_data = imm_u;
			default:  rd_data = alu_result;
		endcase
	end

	assign imem_addr  = pc;
	assign dmem_addr  = alu_result;
	assign dmem_wdata = rs2_data;
	assign dmem_we    = mem_we;

endmodule

`default_nettype wire

//--- rtl/rv_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    en,
	input  rv_pkg::branch_e         branch,
	input  logic [rv_pkg::XLEN-1:0] rs1_data,
	input  logic [rv_pkg::XLEN-1:0] rs2_data,
	input  logic [rv_pkg::XLEN-1:0] imm_b,
	input  logic [rv_pkg::XLEN-1:0] imm_j,
	output logic [rv_pkg::XLEN-1:0] pc,
	output logic [rv_pkg::XLEN-1:0] pc_plus4
);

	import rv_pkg::*;

	logic            taken;
	logic [XLEN-1:0] target;
	logic [XLEN-1:0] next_pc;

	always_comb begin
		case (branch)
			BR_EQ:   taken = (rs1_data == rs2_data);
			BR_NE:   taken = (rs1_data != rs2_data);
			BR_LT:   taken = $signed(rs1_data) < $signed(rs2_data);
			BR_GE:   taken = $signed(rs1_data) >= $signed(rs2_data);
			BR_JUMP: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign pc_plus4 = pc + 32'd4;
	assign target   = pc + ((branch == BR_JUMP) ? imm_j : imm_b);
	assign next_pc  = taken ? target : pc_plus4;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else if (en) begin
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

//--- rtl/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
	input  rv_pkg::alu_op_e         op,
	input  logic [rv_pkg::XLEN-1:0] a,
	input  logic [rv_pkg::XLEN-1:0] b,
	output logic [rv_pkg::XLEN-1:0] result
);

	import rv_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = b[4:0];
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_SLL:  result = a << shamt;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
			default:  result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [4:0]              rs1_addr,
	input  logic [4:0]              rs2_addr,
	output logic [rv_pkg::XLEN-1:0] rs1_data,
	output logic [rv_pkg::XLEN-1:0] rs2_data,
	input  logic                    we,
	input  logic [4:0]              rd_addr,
	input  logic [rv_pkg::XLEN-1:0] rd_data
);

	import rv_pkg::*;

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd_addr != 5'd0) begin
			regs[rd_addr] <= rd_data;
		end
	end

	// x0 is never written, so it reads back as zero
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

//--- rtl/rv_control.sv
`timescale 1ns/1ps
`default_nettype none

module rv_control (
	input  logic            clk,
	input  logic            rst_n,
	input  rv_pkg::opcode_e opcode,
	input  logic [2:0]      funct3,
	input  logic [6:0]      funct7,
	output rv_pkg::alu_op_e alu_op,
	output logic            alu_src_imm,
	output rv_pkg::branch_e branch,
	output logic            reg_we,
	output rv_pkg::wb_sel_e wb_sel,
	output logic            mem_we,
	output logic            pc_en,
	output logic            halted,
	output logic            illegal
);

	import rv_pkg::*;

	ctrl_state_e state;
	logic        illegal_q;
	logic        halt_req;
	logic        illegal_req;
	logic        f7_ok;

	// Only funct7 of 0 or 0x20 exists, and 0x20 only for SUB and SRA
	assign f7_ok = (funct7 == 7'h00) ||
		((funct7 == 7'h20) && ((funct3 == 3'd0) || (funct3 == 3'd5)));

	always_comb begin
		alu_op      = ALU_ADD;
		alu_src_imm = 1'b0;
		branch      = BR_NONE;
		reg_we      = 1'b0;
		wb_sel      = WB_ALU;
		mem_we      = 1'b0;
		pc_en       = 1'b0;
		halt_req    = 1'b0;
		illegal_req = 1'b0;
		if (state == ST_RUN) begin
			pc_en = 1'b1;
			case (opcode)
				OPC_OP: begin
					reg_we = 1'b1;
					illegal_req = !f7_ok;
					case (funct3)
						3'd0: alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
						3'd1: alu_op = ALU_SLL;
						3'd2: alu_op = ALU_SLT;
						3'd3: alu_op = ALU_SLTU;
						3'd4: alu_op = ALU_XOR;
						3'd5: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
						3'd6: alu_op = ALU_OR;
						default: alu_op = ALU_AND;
					endcase
				end
				OPC_OP_IMM: begin
					reg_we = 1'b1;
					alu_src_imm = 1'b1;
					case (funct3)
						3'd0: alu_op = ALU_ADD;
						3'd2: alu_op = ALU_SLT;
						3'd4: alu_op = ALU_XOR;
						3'd6: alu_op = ALU_OR;
						3'd7: alu_op = ALU_AND;
						// SLTIU and immediate shifts are not implemented
						default: illegal_req = 1'b1;
					endcase
				end
				OPC_LOAD: begin
					reg_we = 1'b1;
					alu_src_imm = 1'b1;
					wb_sel = WB_MEM;
					illegal_req = (funct3 != 3'b010);
				end
				OPC_STORE: begin
					mem_we = 1'b1;
					alu_src_imm = 1'b1;
					illegal_req = (funct3 != 3'b010);
				end
				OPC_BRANCH: begin
					case (funct3)
						3'd0: branch = BR_EQ;
						3'd1: branch = BR_NE;
						3'd4: branch = BR_LT;
						3'd5: branch = BR_GE;
						default: illegal_req = 1'b1;
					endcase
				end
				OPC_JAL: begin
					branch = BR_JUMP;
					reg_we = 1'b1;
					wb_sel = WB_PC4;
				end
				OPC_LUI: begin
					reg_we = 1'b1;
					wb_sel = WB_IMM_U;
				end
				OPC_SYSTEM: begin
					// ECALL stops the core cleanly
					halt_req = 1'b1;
					illegal_req = (funct3 != 3'd0);
				end
				default: illegal_req = 1'b1;
			endcase
			if (halt_req || illegal_req) begin
				halt_req = 1'b1;
				reg_we = 1'b0;
				mem_we = 1'b0;
				pc_en = 1'b0;
				branch = BR_NONE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_RUN;
			illegal_q <= 1'b0;
		end else if (state == ST_RUN && halt_req) begin
			state <= ST_HALT;
			illegal_q <= illegal_req;
		end
	end

	assign halted  = (state == ST_HALT);
	assign illegal = illegal_q;

endmodule

`default_nettype wire

//--- rtl/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input  logic [31:0]             instr,
	output rv_pkg::opcode_e         opcode,
	output logic [2:0]              funct3,
	output logic [6:0]              funct7,
	output logic [4:0]              rs1,
	output logic [4:0]              rs2,
	output logic [4:0]              rd,
	output logic [rv_pkg::XLEN-1:0] imm_i,
	output logic [rv_pkg::XLEN-1:0] imm_s,
	output logic [rv_pkg::XLEN-1:0] imm_b,
	output logic [rv_pkg::XLEN-1:0] imm_u,
	output logic [rv_pkg::XLEN-1:0] imm_j
);

	import rv_pkg::*;

	// Field positions are fixed across formats
	assign opcode = opcode_e'(instr[6:0]);
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};

	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

	// Branch offset in halfwords, bit 0 always zero
	assign imm_b = {
		{19{instr[31]}},
		instr[31],
		instr[7],
		instr[30:25],
		instr[11:8],
		1'b0
	};

	assign imm_u = {instr[31:12], 12'h000};

	// Jump offset, same scrambled layout as the ISA manual
	assign imm_j = {
		{11{instr[31]}},
		instr[31],
		instr[19:12],
		instr[20],
		instr[30:21],
		1'b0
	};

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int XLEN = 32;
	localparam int NUM_REGS = 32;
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// Major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_JUMP
	} branch_e;

	// Register write-back source
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4,
		WB_IMM_U
	} wb_sel_e;

	typedef enum logic {
		ST_RUN,
		ST_HALT
	} ctrl_state_e;

endpackage

`default_nettype wire
